/* verilog/adapter_consts.svh */
// Adapter constants
`ifndef ADAPTER_CONSTS_SVH
`define ADAPTER_CONSTS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define ADDR_W 32
`define ID_W 4
`define BEAT_W 64

// ----------------------------------------
// cache line geometry
// ----------------------------------------
`define LINE_BEATS 4
`define BEAT_IDX_W 2
// byte offset bits inside one beat and one line
`define BEAT_OFFSET 3
`define LINE_OFFSET 5

// AXI encodings
`define AXI_BURST_INCR 2'b01
`define AXI_RESP_OKAY 2'b00

`endif

/* verilog/adapter_pkg.sv */
// Adapter types
`default_nettype none

`include "adapter_consts.svh"

package adapter_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`ID_W-1:0] id_t;
  typedef logic [`BEAT_W-1:0] beat_t;
  typedef logic [`BEAT_W/8-1:0] strb_t;
  typedef beat_t [`LINE_BEATS-1:0] line_t;
  typedef strb_t [`LINE_BEATS-1:0] line_strb_t;

  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  // ----------------------------------------
  // cache side
  // ----------------------------------------
  typedef struct packed {
    logic       we;
    req_kind_e  kind;
    addr_t      addr;
    id_t        id;
    logic [2:0] size;
    line_t      wdata;
    line_strb_t wstrb;
  } cache_req_t;

  typedef struct packed {
    line_t rdata;
    id_t   id;
  } cache_rsp_t;

  // engine completion, line is zero for writes
  typedef struct packed {
    line_t line;
    id_t   id;
  } eng_done_t;

  // ----------------------------------------
  // AXI channels
  // ----------------------------------------
  typedef struct packed {
    addr_t      addr;
    id_t        id;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_aw_t;

  // read address carries the same fields
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    beat_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    beat_t      data;
    id_t        id;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  typedef struct packed {
    logic    aw_valid;
    axi_aw_t aw;
    logic    w_valid;
    axi_w_t  w;
    logic    b_ready;
    logic    ar_valid;
    axi_ar_t ar;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    logic   b_valid;
    axi_b_t b;
    logic   ar_ready;
    logic   r_valid;
    axi_r_t r;
  } axi_rsp_t;

  // address phase of a request, line requests start at the line base
  function automatic axi_aw_t ax_from_req(cache_req_t req);
    axi_aw_t ax;
    ax.addr  = req.addr;
    ax.id    = req.id;
    ax.len   = '0;
    ax.size  = req.size;
    ax.burst = `AXI_BURST_INCR;
    if (req.kind == REQ_LINE) begin
      ax.addr[`LINE_OFFSET-1:0] = '0;
      ax.len  = 8'(`LINE_BEATS - 1);
      ax.size = 3'(`BEAT_OFFSET);
    end
    return ax;
  endfunction

endpackage

`default_nettype wire

/* verilog/adapter_front.sv */
// Cache request front end
`default_nettype none

module adapter_front import adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // cache request side
  input  logic       req_i,
  input  cache_req_t req_data_i,
  output logic       gnt_o,
  output logic       busy_o,
  // engine control
  output cache_req_t cmd_o,
  output logic       wr_start_o,
  output logic       rd_start_o,
  input  logic       wr_done_i,
  input  eng_done_t  wr_result_i,
  input  logic       rd_done_i,
  input  eng_done_t  rd_result_i,
  // cache response side
  output logic       rsp_valid_o,
  output cache_rsp_t rsp_o
);

  logic       busy_q;
  logic       wr_start_q;
  logic       rd_start_q;
  logic       rsp_valid_q;
  logic       eng_done;
  eng_done_t  done_sel;
  cache_req_t cmd_q;
  cache_rsp_t rsp_q;

  // one request in flight, grant only while idle
  assign gnt_o  = req_i & ~busy_q;
  assign busy_o = busy_q;

  // engines never finish in the same cycle
  assign eng_done = wr_done_i | rd_done_i;
  assign done_sel = wr_done_i ? wr_result_i : rd_result_i;

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      wr_start_q  <= 1'b0;
      rd_start_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      // start strobe follows the grant by one cycle
      wr_start_q  <= gnt_o & req_data_i.we;
      rd_start_q  <= gnt_o & ~req_data_i.we;
      rsp_valid_q <= eng_done;
      if (gnt_o) begin
        busy_q <= 1'b1;
      end else if (eng_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // latched command and response
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      cmd_q <= req_data_i;
    end
    if (eng_done) begin
      rsp_q.rdata <= done_sel.line;
      rsp_q.id    <= done_sel.id;
    end
  end

  assign cmd_o       = cmd_q;
  assign wr_start_o  = wr_start_q;
  assign rd_start_o  = rd_start_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

/* verilog/axi_write_ctrl.sv */
// AXI write engine
`default_nettype none

`include "adapter_consts.svh"

module axi_write_ctrl import adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  cache_req_t cmd_i,
  // AW channel
  output logic       aw_valid_o,
  output axi_aw_t    aw_o,
  input  logic       aw_ready_i,
  // W channel
  output logic       w_valid_o,
  output axi_w_t     w_o,
  input  logic       w_ready_i,
  // B channel
  input  logic       b_valid_i,
  input  axi_b_t     b_i,
  output logic       b_ready_o,
  // completion
  output logic       done_o,
  output eng_done_t  result_o
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_SEND,
    W_ADDR,
    W_RESP
  } wr_state_e;

  wr_state_e              state_q, state_d;
  logic                   aw_sent_q, aw_sent_d;
  logic [`BEAT_IDX_W-1:0] cnt_q, cnt_d;
  logic                   is_line;
  logic                   last_beat;
  logic                   aw_hs;
  logic                   w_hs;

  assign is_line   = cmd_i.kind == REQ_LINE;
  // a single write is its own last beat
  assign last_beat = !is_line || (cnt_q == `BEAT_IDX_W'(`LINE_BEATS - 1));

  // AW and W run independently while sending
  assign aw_valid_o = ((state_q == W_SEND) && !aw_sent_q) || (state_q == W_ADDR);
  assign w_valid_o  = state_q == W_SEND;
  assign b_ready_o  = state_q == W_RESP;

  assign aw_hs = aw_valid_o & aw_ready_i;
  assign w_hs  = w_valid_o & w_ready_i;

  assign aw_o   = ax_from_req(cmd_i);
  assign w_o.data = cmd_i.wdata[cnt_q];
  assign w_o.strb = cmd_i.wstrb[cnt_q];
  assign w_o.last = last_beat;

  // write response carries no data
  assign result_o.line = '0;
  assign result_o.id   = b_i.id;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    aw_sent_d = aw_sent_q;
    cnt_d     = cnt_q;
    done_o    = 1'b0;
    case (state_q)
      W_IDLE: begin
        if (start_i) begin
          state_d   = W_SEND;
          aw_sent_d = 1'b0;
          cnt_d     = '0;
        end
      end
      W_SEND: begin
        if (aw_hs) begin
          aw_sent_d = 1'b1;
        end
        if (w_hs) begin
          if (last_beat) begin
            // data done, wait for the address if it is still pending
            state_d = (aw_sent_q || aw_hs) ? W_RESP : W_ADDR;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      W_ADDR: begin
        if (aw_hs) begin
          state_d = W_RESP;
        end
      end
      W_RESP: begin
        if (b_valid_i) begin
          done_o  = 1'b1;
          state_d = W_IDLE;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= W_IDLE;
      aw_sent_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      state_q   <= state_d;
      aw_sent_q <= aw_sent_d;
      cnt_q     <= cnt_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_read_ctrl.sv */
// AXI read engine
`default_nettype none

`include "adapter_consts.svh"

module axi_read_ctrl import adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  cache_req_t cmd_i,
  // AR channel
  output logic       ar_valid_o,
  output axi_ar_t    ar_o,
  input  logic       ar_ready_i,
  // R channel
  input  logic       r_valid_i,
  input  axi_r_t     r_i,
  output logic       r_ready_o,
  // completion
  output logic       done_o,
  output eng_done_t  result_o,
  // critical word of a line read
  output logic       crit_valid_o,
  output beat_t      crit_word_o
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_ADDR,
    R_DATA,
    R_DONE
  } rd_state_e;

  rd_state_e              state_q, state_d;
  logic [`BEAT_IDX_W-1:0] cnt_q, cnt_d;
  logic [`BEAT_IDX_W-1:0] slot;
  logic [`BEAT_IDX_W-1:0] crit_idx;
  logic                   is_line;
  logic                   ar_hs;
  logic                   r_hs;
  line_t                  line_q;
  id_t                    id_q;

  assign is_line  = cmd_i.kind == REQ_LINE;
  // beat that holds the requested word
  assign crit_idx = cmd_i.addr[`BEAT_OFFSET +: `BEAT_IDX_W];
  // single reads land in slot 0
  assign slot     = is_line ? cnt_q : '0;

  assign ar_valid_o = state_q == R_ADDR;
  assign r_ready_o  = state_q == R_DATA;
  assign ar_hs      = ar_valid_o & ar_ready_i;
  assign r_hs       = r_valid_i & r_ready_o;

  assign ar_o = ax_from_req(cmd_i);

  assign crit_valid_o = r_hs && is_line && (cnt_q == crit_idx);
  assign crit_word_o  = r_i.data;

  assign done_o        = state_q == R_DONE;
  assign result_o.line = line_q;
  assign result_o.id   = id_q;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      R_IDLE: begin
        if (start_i) begin
          state_d = R_ADDR;
          cnt_d   = '0;
        end
      end
      R_ADDR: begin
        if (ar_hs) begin
          state_d = R_DATA;
        end
      end
      R_DATA: begin
        if (r_hs) begin
          cnt_d = cnt_q + 1'b1;
          if (r_i.last) begin
            state_d = R_DONE;
          end
        end
      end
      R_DONE:  state_d = R_IDLE;
      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= R_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // line buffer, cleared so single reads return zero upper beats
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      line_q <= '0;
    end else if (r_hs) begin
      line_q[slot] <= r_i.data;
    end
    if (r_hs && r_i.last) begin
      id_q <= r_i.id;
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_adapter_top.sv */
// Cache to AXI adapter
`default_nettype none

module axi_adapter_top import adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // cache side
  input  logic       req_i,
  input  cache_req_t req_data_i,
  output logic       gnt_o,
  output logic       busy_o,
  output logic       rsp_valid_o,
  output cache_rsp_t rsp_o,
  output logic       crit_valid_o,
  output beat_t      crit_word_o,
  // AXI master port
  output axi_req_t   axi_req_o,
  input  axi_rsp_t   axi_rsp_i
);

  cache_req_t cmd;
  logic       wr_start;
  logic       rd_start;
  logic       wr_done;
  logic       rd_done;
  eng_done_t  wr_result;
  eng_done_t  rd_result;

  // engine channel outputs
  logic    aw_valid;
  axi_aw_t aw;
  logic    w_valid;
  axi_w_t  w;
  logic    b_ready;
  logic    ar_valid;
  axi_ar_t ar;
  logic    r_ready;

  adapter_front i_front (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .gnt_o       (gnt_o),
    .busy_o      (busy_o),
    .cmd_o       (cmd),
    .wr_start_o  (wr_start),
    .rd_start_o  (rd_start),
    .wr_done_i   (wr_done),
    .wr_result_i (wr_result),
    .rd_done_i   (rd_done),
    .rd_result_i (rd_result),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  axi_write_ctrl i_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (wr_start),
    .cmd_i      (cmd),
    .aw_valid_o (aw_valid),
    .aw_o       (aw),
    .aw_ready_i (axi_rsp_i.aw_ready),
    .w_valid_o  (w_valid),
    .w_o        (w),
    .w_ready_i  (axi_rsp_i.w_ready),
    .b_valid_i  (axi_rsp_i.b_valid),
    .b_i        (axi_rsp_i.b),
    .b_ready_o  (b_ready),
    .done_o     (wr_done),
    .result_o   (wr_result)
  );

  axi_read_ctrl i_read (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (rd_start),
    .cmd_i        (cmd),
    .ar_valid_o   (ar_valid),
    .ar_o         (ar),
    .ar_ready_i   (axi_rsp_i.ar_ready),
    .r_valid_i    (axi_rsp_i.r_valid),
    .r_i          (axi_rsp_i.r),
    .r_ready_o    (r_ready),
    .done_o       (rd_done),
    .result_o     (rd_result),
    .crit_valid_o (crit_valid_o),
    .crit_word_o  (crit_word_o)
  );

  // ----------------------------------------
  // merge engine channels onto the bus
  // ----------------------------------------
  assign axi_req_o.aw_valid = aw_valid;
  assign axi_req_o.aw       = aw;
  assign axi_req_o.w_valid  = w_valid;
  assign axi_req_o.w        = w;
  assign axi_req_o.b_ready  = b_ready;
  assign axi_req_o.ar_valid = ar_valid;
  assign axi_req_o.ar       = ar;
  assign axi_req_o.r_ready  = r_ready;

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
// AXI memory slave model
`default_nettype none

`include "adapter_consts.svh"

module axi_mem_model import adapter_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  axi_req_t axi_req_i,
  output axi_rsp_t axi_rsp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  beat_t      mem [256];
  axi_rsp_t   rsp;
  logic       aw_got;
  addr_t      w_addr;
  id_t        w_id;
  logic [7:0] w_beat;
  logic       ar_got;
  addr_t      r_addr;
  id_t        r_id;
  logic [7:0] r_len;
  logic [7:0] r_beat;

  // word index of one beat inside a burst, wraps at 256 words
  function automatic logic [7:0] word_index(addr_t addr, logic [7:0] beat);
    return addr[`BEAT_OFFSET +: 8] + beat;
  endfunction

  // ready asserted about three cycles in four
  function automatic logic random_ready();
    return ($urandom % 4) != 0;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] = {32'(i), 32'(i)};
      end
      aw_got = 1'b0;
      ar_got = 1'b0;
      rsp    = '0;
    end else begin
      // ----------------------------------------
      // write side, data taken only after the address
      // ----------------------------------------
      if (rsp.b_valid && axi_req_i.b_ready) begin
        rsp.b_valid = 1'b0;
      end
      if (rsp.aw_ready && axi_req_i.aw_valid) begin
        aw_got = 1'b1;
        w_addr = axi_req_i.aw.addr;
        w_id   = axi_req_i.aw.id;
        w_beat = '0;
      end
      if (rsp.w_ready && axi_req_i.w_valid) begin
        for (int k = 0; k < `BEAT_W / 8; k++) begin
          if (axi_req_i.w.strb[k]) begin
            mem[word_index(w_addr, w_beat)][8*k +: 8] = axi_req_i.w.data[8*k +: 8];
          end
        end
        w_beat = w_beat + 1'b1;
        if (axi_req_i.w.last) begin
          aw_got      = 1'b0;
          rsp.b_valid = 1'b1;
          rsp.b.id    = w_id;
          rsp.b.resp  = `AXI_RESP_OKAY;
        end
      end
      rsp.aw_ready = !aw_got && !rsp.b_valid && random_ready();
      rsp.w_ready  = aw_got && random_ready();
      // ----------------------------------------
      // read side
      // ----------------------------------------
      if (rsp.r_valid && axi_req_i.r_ready) begin
        rsp.r_valid = 1'b0;
        if (rsp.r.last) begin
          ar_got = 1'b0;
        end
        r_beat = r_beat + 1'b1;
      end
      if (rsp.ar_ready && axi_req_i.ar_valid) begin
        ar_got = 1'b1;
        r_addr = axi_req_i.ar.addr;
        r_id   = axi_req_i.ar.id;
        r_len  = axi_req_i.ar.len;
        r_beat = '0;
      end
      if (ar_got && !rsp.r_valid && random_ready()) begin
        rsp.r_valid = 1'b1;
        rsp.r.data  = mem[word_index(r_addr, r_beat)];
        rsp.r.id    = r_id;
        rsp.r.resp  = `AXI_RESP_OKAY;
        rsp.r.last  = r_beat == r_len;
      end
      rsp.ar_ready = !ar_got && random_ready();
    end
    axi_rsp_o <= rsp;
  end

endmodule

`default_nettype wire

/* sim/adapter_properties.sv */
// Adapter bus properties
`default_nettype none

module adapter_properties import adapter_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     gnt_i,
  input logic     rsp_valid_i,
  input axi_req_t axi_req_i,
  input axi_rsp_t axi_rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic in_flight_q;

  // set by a grant and cleared by the response strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= 1'b0;
    end else if (gnt_i) begin
      in_flight_q <= 1'b1;
    end else if (rsp_valid_i) begin
      in_flight_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // payloads hold while stalled
  // ----------------------------------------
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.aw_valid && !axi_rsp_i.aw_ready |=> axi_req_i.aw_valid && $stable(axi_req_i.aw))
    else $error("aw payload changed while stalled");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.w_valid && !axi_rsp_i.w_ready |=> axi_req_i.w_valid && $stable(axi_req_i.w))
    else $error("w payload changed while stalled");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.ar_valid && !axi_rsp_i.ar_ready |=> axi_req_i.ar_valid && $stable(axi_req_i.ar))
    else $error("ar payload changed while stalled");

  // cache side
  // a new grant only once the previous response has arrived
  one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> !in_flight_q || rsp_valid_i)
    else $error("grant raised while a request is in flight");

  rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("response strobe longer than one cycle");

endmodule

`default_nettype wire

/* sim/tb_axi_adapter.sv */
// Adapter testbench
`default_nettype none

`include "adapter_consts.svh"

module tb_axi_adapter import adapter_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 5;
  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       rst_n;
  logic       req;
  cache_req_t req_data;
  logic       gnt;
  logic       busy;
  logic       rsp_valid;
  cache_rsp_t rsp;
  logic       crit_valid;
  beat_t      crit_word;
  axi_req_t   axi_req;
  axi_rsp_t   axi_rsp;

  // monitor results
  int         crit_count;
  beat_t      crit_seen;
  axi_ar_t    ar_seen;

  axi_adapter_top DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .req_data_i   (req_data),
    .gnt_o        (gnt),
    .busy_o       (busy),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .crit_valid_o (crit_valid),
    .crit_word_o  (crit_word),
    .axi_req_o    (axi_req),
    .axi_rsp_i    (axi_rsp)
  );

  axi_mem_model i_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

  bind axi_adapter_top adapter_properties i_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .gnt_i       (gnt_o),
    .rsp_valid_i (rsp_valid_o),
    .axi_req_i   (axi_req_o),
    .axi_rsp_i   (axi_rsp_i)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (crit_valid) begin
      crit_count = crit_count + 1;
      crit_seen  = crit_word;
    end
    if (axi_req.ar_valid && axi_rsp.ar_ready) begin
      ar_seen = axi_req.ar;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error: %s is %0h, expected %0h", name, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // memory starts with the word index in both halves
  function automatic beat_t initial_word(addr_t addr);
    logic [31:0] idx;
    idx = 32'(addr[10:3]);
    return {idx, idx};
  endfunction

  function automatic beat_t merge_bytes(beat_t old_word, beat_t new_word, strb_t strb);
    beat_t word;
    word = old_word;
    for (int k = 0; k < `BEAT_W / 8; k++) begin
      if (strb[k]) begin
        word[8*k +: 8] = new_word[8*k +: 8];
      end
    end
    return word;
  endfunction

  function automatic cache_req_t make_request(logic we, req_kind_e kind, addr_t addr, id_t id,
                                              line_t wdata, line_strb_t wstrb);
    cache_req_t r;
    r.we    = we;
    r.kind  = kind;
    r.addr  = addr;
    r.id    = id;
    r.size  = 3'(`BEAT_OFFSET);
    r.wdata = wdata;
    r.wstrb = wstrb;
    return r;
  endfunction

  // holds the request until granted and returns in the cycle after the grant
  task automatic send_request(input cache_req_t r);
    int cycles;
    cycles   = 0;
    req      = 1'b1;
    req_data = r;
    #1;
    while (!gnt) begin
      if (cycles == WAIT_LIMIT) begin
        stop_with_failure("request was never granted");
      end
      @(posedge clk);
      #3;
      cycles++;
    end
    next_cycle();
    req = 1'b0;
  endtask

  task automatic wait_response(output cache_rsp_t r);
    int cycles;
    cycles = 0;
    while (!rsp_valid) begin
      check_value("busy_o", busy, 1'b1);
      if (cycles == WAIT_LIMIT) begin
        stop_with_failure("no response arrived for the request");
      end
      next_cycle();
      cycles++;
    end
    r = rsp;
    check_value("busy_o", busy, 1'b0);
    next_cycle();
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic idle_after_reset();
    repeat (10) begin
      check_value("busy_o", busy, 1'b0);
      check_value("rsp_valid_o", rsp_valid, 1'b0);
      check_value("crit_valid_o", crit_valid, 1'b0);
      check_value("aw_valid", axi_req.aw_valid, 1'b0);
      check_value("w_valid", axi_req.w_valid, 1'b0);
      check_value("ar_valid", axi_req.ar_valid, 1'b0);
      check_value("b_ready", axi_req.b_ready, 1'b0);
      check_value("r_ready", axi_req.r_ready, 1'b0);
      next_cycle();
    end
  endtask

  task automatic single_write_then_read();
    addr_t      addr;
    beat_t      data;
    strb_t      strb;
    line_t      wline;
    line_strb_t wstrb;
    cache_rsp_t r;
    addr     = 32'h0000_0048;
    data     = {$urandom, $urandom};
    strb     = 8'h35;
    wline    = '0;
    wline[0] = data;
    wstrb    = '0;
    wstrb[0] = strb;
    send_request(make_request(1'b1, REQ_SINGLE, addr, 4'h3, wline, wstrb));
    wait_response(r);
    check_value("rsp_o.id", r.id, 4'h3);
    check_value("rsp_o.rdata", r.rdata, '0);
    send_request(make_request(1'b0, REQ_SINGLE, addr, 4'h5, '0, '0));
    wait_response(r);
    check_value("rsp_o.id", r.id, 4'h5);
    check_value("rsp_o.rdata[0]", r.rdata[0], merge_bytes(initial_word(addr), data, strb));
  endtask

  task automatic line_write_then_read();
    addr_t      base;
    addr_t      addr;
    line_t      wline;
    cache_rsp_t r;
    base = 32'h0000_0100;
    addr = base + 32'h14;
    for (int j = 0; j < `LINE_BEATS; j++) begin
      wline[j] = {$urandom, $urandom};
    end
    send_request(make_request(1'b1, REQ_LINE, base, 4'h7, wline, '1));
    wait_response(r);
    check_value("rsp_o.id", r.id, 4'h7);
    ar_seen = '1;
    send_request(make_request(1'b0, REQ_LINE, addr, 4'h9, '0, '0));
    wait_response(r);
    check_value("rsp_o.id", r.id, 4'h9);
    check_value("rsp_o.rdata", r.rdata, wline);
    check_value("ar.addr", ar_seen.addr, addr & ~32'((1 << `LINE_OFFSET) - 1));
    check_value("ar.len", ar_seen.len, `LINE_BEATS - 1);
  endtask

  task automatic critical_word_offsets();
    addr_t      base;
    addr_t      addr;
    cache_rsp_t r;
    base = 32'h0000_0200;
    for (int k = 0; k < `LINE_BEATS; k++) begin
      addr       = base + 32'(8 * k + 2 * k);
      crit_count = 0;
      send_request(make_request(1'b0, REQ_LINE, addr, 4'(k), '0, '0));
      wait_response(r);
      check_value("rsp_o.id", r.id, 4'(k));
      check_value("crit_valid_o count", crit_count, 1);
      check_value("crit_word_o", crit_seen, initial_word(base + 32'(8 * k)));
      for (int j = 0; j < `LINE_BEATS; j++) begin
        check_value($sformatf("rsp_o.rdata[%0d]", j), r.rdata[j],
                    initial_word(base + 32'(8 * j)));
      end
    end
  endtask

  task automatic held_request_waits();
    addr_t      addr;
    addr_t      base;
    beat_t      data;
    line_t      wline;
    line_strb_t wstrb;
    line_t      expected;
    cache_rsp_t r;
    int         cycles;
    addr     = 32'h0000_03a8;
    base     = 32'h0000_03a0;
    data     = {$urandom, $urandom};
    wline    = '0;
    wline[0] = data;
    wstrb    = '0;
    wstrb[0] = '1;
    send_request(make_request(1'b1, REQ_SINGLE, addr, 4'hb, wline, wstrb));
    // second request held while the first is in flight
    req      = 1'b1;
    req_data = make_request(1'b0, REQ_LINE, addr, 4'hc, '0, '0);
    cycles   = 0;
    #1;
    while (!rsp_valid) begin
      check_value("gnt_o", gnt, 1'b0);
      if (cycles == WAIT_LIMIT) begin
        stop_with_failure("first request never completed");
      end
      @(posedge clk);
      #3;
      cycles++;
    end
    check_value("rsp_o.id", rsp.id, 4'hb);
    check_value("gnt_o", gnt, 1'b1);
    next_cycle();
    req = 1'b0;
    wait_response(r);
    for (int j = 0; j < `LINE_BEATS; j++) begin
      expected[j] = initial_word(base + 32'(8 * j));
    end
    // the written word sits one beat above the line base
    expected[(addr - base) >> `BEAT_OFFSET] = data;
    check_value("rsp_o.id", r.id, 4'hc);
    check_value("rsp_o.rdata", r.rdata, expected);
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    void'($urandom(32'h9842974c));
    rst_n      = 1'b0;
    req        = 1'b0;
    req_data   = '0;
    crit_count = 0;
    crit_seen  = '0;
    ar_seen    = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idle_after_reset();
    single_write_then_read();
    line_write_then_read();
    critical_word_offsets();
    held_request_waits();
    $display("TEST PASS");
    $finish;
  end

  initial begin
    #(NUM_TESTS * 2000);
    stop_with_failure("timeout, the tests did not finish in time");
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/adapter_pkg.sv
verilog/adapter_front.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/axi_adapter_top.sv
sim/axi_mem_model.sv
sim/adapter_properties.sv
sim/tb_axi_adapter.sv
